// File: source/conv_load_consts.svh
`ifndef CONV_LOAD_CONSTS_SVH
`define CONV_LOAD_CONSTS_SVH

////////////////////////////////////////
// pixel word geometry
////////////////////////////////////////

// pixels held in one ddr word row
`define PIXELS_IN_ROW 32
`define PIXELS_IN_ROW_LOG2 5

// input channels packed per word, log2
`define IFS_IN_WORD_LOG2 1

////////////////////////////////////////
// buffers and chunks
////////////////////////////////////////

// row buffers, also the tile y step
`define BUFFERS_NUM 3
// depth of one row buffer, log2
`define INPUT_BUFFER_SIZE_LOG2 12

// output feature chunk per mode
`define ROW_NUM_MODE0 64
`define ROW_NUM_MODE1 128

`endif

// File: source/conv_load_pkg.sv
package conv_load_pkg;

  // ddr and row buffer word address
  typedef logic [15:0] word_adr_t;

  // one-based loop index or pixel coordinate
  typedef logic [15:0] loop_idx_t;

  // word or row count of a tile
  typedef logic [7:0] size_t;

  // shift amount for address mapping
  typedef logic [3:0] shift_t;

  // row buffer number, 1 to 3
  typedef logic [1:0] row_buf_idx_t;

  // word pushed into the load info fifo
  typedef struct packed {
    logic [13:0]  pad;
    row_buf_idx_t row_buf_idx;
    word_adr_t    row_buf_adr;
  } load_info_t;

  // input tile state at the current x/y position
  typedef enum logic [1:0] {
    TILE_PENDING = 2'd0,
    TILE_LOADING = 2'd1,
    TILE_LOADED  = 2'd2
  } tile_state_e;

endpackage

// File: source/conv_load_ifs.sv
// layer configuration, fixed after reset
interface layer_cfg_if;
  import conv_load_pkg::*;

  logic      mode;
  loop_idx_t row_num;
  loop_idx_t of_num;
  loop_idx_t ox;
  loop_idx_t oy;
  loop_idx_t nif;
  // words per input row and rows per plane, as shifts
  shift_t    word_shift;
  shift_t    row_shift;
  word_adr_t row_limit_mask;
  word_adr_t ddr_base_adr;
  // tile sizes for first, middle and last positions
  size_t     tilex_first_ix_word_num;
  size_t     tilex_mid_ix_word_num;
  size_t     tilex_last_ix_word_num;
  size_t     tiley_first_iy_row_num;
  size_t     tiley_mid_iy_row_num;
  size_t     tiley_last_iy_row_num;
  loop_idx_t ix_index_num;
  loop_idx_t iy_index_num;

  modport cfg_src (
    output mode, row_num, of_num, ox, oy, nif, word_shift, row_shift,
    output row_limit_mask, ddr_base_adr,
    output tilex_first_ix_word_num, tilex_mid_ix_word_num, tilex_last_ix_word_num,
    output tiley_first_iy_row_num, tiley_mid_iy_row_num, tiley_last_iy_row_num,
    output ix_index_num, iy_index_num
  );
  modport cfg_seq (
    input row_num, of_num, ox, oy,
    input tilex_first_ix_word_num, tilex_mid_ix_word_num, tilex_last_ix_word_num,
    input tiley_first_iy_row_num, tiley_mid_iy_row_num, tiley_last_iy_row_num
  );
  modport cfg_walk (input nif, ix_index_num, iy_index_num);
  modport cfg_adr (input word_shift, row_shift, row_limit_mask, ddr_base_adr);
endinterface

// tile load start and completion between sequencer and walker
interface tile_load_if;
  import conv_load_pkg::*;

  logic      load_start;
  loop_idx_t tile_words;
  logic      load_done;

  modport seq (output load_start, tile_words, input load_done);
  modport walk (input load_start, tile_words, output load_done);
endinterface

// File: source/layer_config_reg.sv
`include "conv_load_consts.svh"

module layer_config_reg (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     mode_init,
  input  conv_load_pkg::loop_idx_t of_init,
  input  conv_load_pkg::loop_idx_t ox_init,
  input  conv_load_pkg::loop_idx_t oy_init,
  input  conv_load_pkg::loop_idx_t nif_init,
  input  conv_load_pkg::shift_t    nif_in_2pow_init,
  input  conv_load_pkg::shift_t    ix_in_2pow_init,
  input  conv_load_pkg::word_adr_t input_ddr_layer_base_adr_init,
  input  conv_load_pkg::size_t     tilex_first_ix_word_num_init,
  input  conv_load_pkg::size_t     tilex_mid_ix_word_num_init,
  input  conv_load_pkg::size_t     tilex_last_ix_word_num_init,
  input  conv_load_pkg::size_t     tiley_first_iy_row_num_init,
  input  conv_load_pkg::size_t     tiley_mid_iy_row_num_init,
  input  conv_load_pkg::size_t     tiley_last_iy_row_num_init,
  input  conv_load_pkg::loop_idx_t ix_index_num_init,
  input  conv_load_pkg::loop_idx_t iy_index_num_init,
  layer_cfg_if.cfg_src             cfg
);
  import conv_load_pkg::*;

  // log2 of channel count and input width
  shift_t     nif_in_2pow;
  shift_t     ix_in_2pow;
  // rows of one layer that fit into a row buffer, log2
  logic [4:0] row_limit_log2;

  // new layer is latched on every reset cycle, held afterwards
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.mode                    <= mode_init;
      cfg.of_num                  <= of_init;
      cfg.ox                      <= ox_init;
      cfg.oy                      <= oy_init;
      cfg.nif                     <= nif_init;
      nif_in_2pow                 <= nif_in_2pow_init;
      ix_in_2pow                  <= ix_in_2pow_init;
      cfg.ddr_base_adr            <= input_ddr_layer_base_adr_init;
      cfg.tilex_first_ix_word_num <= tilex_first_ix_word_num_init;
      cfg.tilex_mid_ix_word_num   <= tilex_mid_ix_word_num_init;
      cfg.tilex_last_ix_word_num  <= tilex_last_ix_word_num_init;
      cfg.tiley_first_iy_row_num  <= tiley_first_iy_row_num_init;
      cfg.tiley_mid_iy_row_num    <= tiley_mid_iy_row_num_init;
      cfg.tiley_last_iy_row_num   <= tiley_last_iy_row_num_init;
      cfg.ix_index_num            <= ix_index_num_init;
      cfg.iy_index_num            <= iy_index_num_init;
    end
  end

  // output feature chunk, 64 in 8 bit mode, 128 in 1 bit mode
  assign cfg.row_num = cfg.mode ? 16'(`ROW_NUM_MODE1) : 16'(`ROW_NUM_MODE0);

  // words per pixel row position: nif / 2 channels per word
  assign cfg.word_shift = nif_in_2pow - 4'(`IFS_IN_WORD_LOG2);
  // words per input row: word_shift plus ix / 32 pixels
  assign cfg.row_shift = cfg.word_shift + ix_in_2pow - 4'(`PIXELS_IN_ROW_LOG2);

  // buffer row index wraps at the buffer depth
  assign row_limit_log2     = 5'(`INPUT_BUFFER_SIZE_LOG2) - {1'b0, cfg.row_shift};
  assign cfg.row_limit_mask = 16'hffff >> (5'd16 - row_limit_log2);

endmodule

// File: source/tile_position_sequencer.sv
`include "conv_load_consts.svh"

module tile_position_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              conv_load_input,
  layer_cfg_if.cfg_seq      cfg,
  tile_load_if.seq          tl,
  output logic              conv_load_input_fin
);
  import conv_load_pkg::*;

  localparam loop_idx_t X_STEP = 16'(`PIXELS_IN_ROW);
  localparam loop_idx_t Y_STEP = 16'(`BUFFERS_NUM);

  // first output feature of the current chunk
  loop_idx_t   f_start;
  // output tile origin, one based
  loop_idx_t   tile_x_start;
  loop_idx_t   tile_y_start;
  tile_state_e tile_state;

  // input tile extent at this position
  size_t       chunk_width;
  size_t       chunk_height;

  logic        load_req;
  logic        chunk_end;
  logic        f_wrap;
  logic        x_wrap;
  logic        y_wrap;

  ////////////////////////////////////////
  // tile size by position
  ////////////////////////////////////////

  // x: first tile, last tile once past ox - 32, middle otherwise
  always_comb begin
    if (tile_x_start == 16'd1) begin
      chunk_width = cfg.tilex_first_ix_word_num;
    end else if (tile_x_start + X_STEP > cfg.ox) begin
      chunk_width = cfg.tilex_last_ix_word_num;
    end else begin
      chunk_width = cfg.tilex_mid_ix_word_num;
    end
  end

  // y: same split with the buffer count as step
  always_comb begin
    if (tile_y_start == 16'd1) begin
      chunk_height = cfg.tiley_first_iy_row_num;
    end else if (tile_y_start + Y_STEP > cfg.oy) begin
      chunk_height = cfg.tiley_last_iy_row_num;
    end else begin
      chunk_height = cfg.tiley_mid_iy_row_num;
    end
  end

  // words per channel pair over the whole tile
  assign tl.tile_words = 16'(chunk_width) * 16'(chunk_height);

  ////////////////////////////////////////
  // request handling
  ////////////////////////////////////////

  // only a pending tile goes to ddr
  assign load_req = conv_load_input && (tile_state == TILE_PENDING);

  // loaded tile answers at once, a loading one when the walker is done
  assign conv_load_input_fin = (conv_load_input && (tile_state == TILE_LOADED))
                            || ((tile_state == TILE_LOADING) && tl.load_done);
  assign chunk_end = conv_load_input_fin;

  // loop ends for f, x and y
  assign f_wrap = (f_start + cfg.row_num) > cfg.of_num;
  assign x_wrap = (tile_x_start + X_STEP) > cfg.ox;
  assign y_wrap = (tile_y_start + Y_STEP) > cfg.oy;

  always_ff @(posedge clk) begin
    if (reset) begin
      f_start       <= 16'd1;
      tile_x_start  <= 16'd1;
      tile_y_start  <= 16'd1;
      tile_state    <= TILE_PENDING;
      tl.load_start <= 1'b0;
    end else begin
      // one cycle start pulse for the walker
      tl.load_start <= load_req;
      if (load_req) begin
        tile_state <= TILE_LOADING;
      end else if (chunk_end) begin
        if (f_wrap) begin
          // last chunk, move to the next tile position
          f_start    <= 16'd1;
          tile_state <= TILE_PENDING;
          if (x_wrap) begin
            tile_x_start <= 16'd1;
            tile_y_start <= y_wrap ? 16'd1 : tile_y_start + Y_STEP;
          end else begin
            tile_x_start <= tile_x_start + X_STEP;
          end
        end else begin
          f_start    <= f_start + cfg.row_num;
          tile_state <= TILE_LOADED;
        end
      end
    end
  end

endmodule

// File: source/input_word_walker.sv
`include "conv_load_consts.svh"

module input_word_walker (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        ddr_en,
  layer_cfg_if.cfg_walk               cfg,
  tile_load_if.walk                   tl,
  output logic                        rd_en,
  output conv_load_pkg::loop_idx_t    if_start,
  output conv_load_pkg::loop_idx_t    ix_load_index,
  output conv_load_pkg::loop_idx_t    iy_load_index,
  output conv_load_pkg::row_buf_idx_t row_buf_idx,
  output conv_load_pkg::loop_idx_t    row_buf_row
);
  import conv_load_pkg::*;

  // two channels per ddr word
  localparam loop_idx_t IF_STEP = 16'(1 << `IFS_IN_WORD_LOG2);

  logic      loading;
  // words read so far in this tile, one based
  loop_idx_t word_cnt;
  logic      pair_wrap;
  logic      ix_wrap;
  logic      iy_wrap;

  // one read per enabled cycle while a tile is loading
  assign rd_en     = loading && ddr_en;
  assign pair_wrap = rd_en && ((if_start + IF_STEP) > cfg.nif);
  assign ix_wrap   = pair_wrap && (ix_load_index == cfg.ix_index_num);
  assign iy_wrap   = ix_wrap && (iy_load_index == cfg.iy_index_num);

  // last channel pair of the last word in the tile
  assign tl.load_done = pair_wrap && (word_cnt == tl.tile_words);

  always_ff @(posedge clk) begin
    if (reset) begin
      loading <= 1'b0;
    end else if (tl.load_start) begin
      loading <= 1'b1;
    end else if (tl.load_done) begin
      loading <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // channel pair and tile word loops
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      if_start <= 16'd1;
      word_cnt <= 16'd1;
    end else if (rd_en) begin
      if (pair_wrap) begin
        if_start <= 16'd1;
        word_cnt <= tl.load_done ? 16'd1 : word_cnt + 16'd1;
      end else begin
        if_start <= if_start + IF_STEP;
      end
    end
  end

  ////////////////////////////////////////
  // ix/iy load position, kept across tiles
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ix_load_index <= 16'd1;
    end else if (pair_wrap) begin
      ix_load_index <= ix_wrap ? 16'd1 : ix_load_index + 16'd1;
    end
  end

  // buffer number cycles 1, 2, 3, buffer row steps every third iy
  always_ff @(posedge clk) begin
    if (reset) begin
      iy_load_index <= 16'd1;
      row_buf_idx   <= 2'd1;
      row_buf_row   <= 16'd0;
    end else if (ix_wrap) begin
      if (iy_wrap) begin
        iy_load_index <= 16'd1;
        row_buf_idx   <= 2'd1;
        row_buf_row   <= 16'd0;
      end else begin
        iy_load_index <= iy_load_index + 16'd1;
        if (row_buf_idx == 2'(`BUFFERS_NUM)) begin
          row_buf_idx <= 2'd1;
          row_buf_row <= row_buf_row + 16'd1;
        end else begin
          row_buf_idx <= row_buf_idx + 2'd1;
        end
      end
    end
  end

endmodule

// File: source/ddr_buffer_address_gen.sv
`include "conv_load_consts.svh"

module ddr_buffer_address_gen (
  layer_cfg_if.cfg_adr                cfg,
  input  conv_load_pkg::loop_idx_t    if_start,
  input  conv_load_pkg::loop_idx_t    ix_load_index,
  input  conv_load_pkg::loop_idx_t    iy_load_index,
  input  conv_load_pkg::row_buf_idx_t row_buf_idx,
  input  conv_load_pkg::loop_idx_t    row_buf_row,
  input  logic                        rd_en,
  output conv_load_pkg::word_adr_t    ddr_adr,
  output logic                        fifo_en,
  output conv_load_pkg::load_info_t   fifo_word
);
  import conv_load_pkg::*;

  // first pixel of the 32 pixel row, zero based, kept wide before the shift
  logic [31:0] col_pixel;
  // word offset of the pixel row and the channel pair
  word_adr_t   col_ofs;
  word_adr_t   if_ofs;
  word_adr_t   row_ofs;
  word_adr_t   buf_adr;

  assign col_pixel = 32'(ix_load_index - 16'd1) << `PIXELS_IN_ROW_LOG2;
  assign col_ofs   = 16'((col_pixel << cfg.word_shift) >> `PIXELS_IN_ROW_LOG2);
  assign if_ofs    = (if_start - 16'd1) >> `IFS_IN_WORD_LOG2;

  // ddr side, whole input plane row by row
  assign row_ofs = (iy_load_index - 16'd1) << cfg.row_shift;
  assign ddr_adr = cfg.ddr_base_adr + row_ofs + col_ofs + if_ofs;

  // buffer side, every third row lands in the same buffer
  assign buf_adr = ((row_buf_row & cfg.row_limit_mask) << cfg.row_shift) + col_ofs + if_ofs;

  // fifo write goes with every ddr read
  assign fifo_en               = rd_en;
  assign fifo_word.pad         = '0;
  assign fifo_word.row_buf_idx = row_buf_idx;
  assign fifo_word.row_buf_adr = buf_adr;

endmodule

// File: source/conv_input_load_top.sv
module conv_input_load_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     conv_load_input,
  input  logic                     ddr_en,
  // layer configuration, sampled while reset is high
  input  logic                     mode_init,
  input  conv_load_pkg::loop_idx_t of_init,
  input  conv_load_pkg::loop_idx_t ox_init,
  input  conv_load_pkg::loop_idx_t oy_init,
  input  conv_load_pkg::loop_idx_t nif_init,
  input  conv_load_pkg::shift_t    nif_in_2pow_init,
  input  conv_load_pkg::shift_t    ix_in_2pow_init,
  input  conv_load_pkg::word_adr_t input_ddr_layer_base_adr_init,
  input  conv_load_pkg::size_t     tilex_first_ix_word_num_init,
  input  conv_load_pkg::size_t     tilex_mid_ix_word_num_init,
  input  conv_load_pkg::size_t     tilex_last_ix_word_num_init,
  input  conv_load_pkg::size_t     tiley_first_iy_row_num_init,
  input  conv_load_pkg::size_t     tiley_mid_iy_row_num_init,
  input  conv_load_pkg::size_t     tiley_last_iy_row_num_init,
  input  conv_load_pkg::loop_idx_t ix_index_num_init,
  input  conv_load_pkg::loop_idx_t iy_index_num_init,
  // ddr read and load info fifo write
  output logic                     input_word_ddr_en_rd,
  output conv_load_pkg::word_adr_t input_word_ddr_adr_rd,
  output logic                     input_word_load_info_fifo_en_wt,
  output conv_load_pkg::load_info_t input_word_load_info_fifo_wt,
  output logic                     conv_load_input_fin
);
  import conv_load_pkg::*;

  // walker indices into the address generator
  loop_idx_t    if_start;
  loop_idx_t    ix_load_index;
  loop_idx_t    iy_load_index;
  row_buf_idx_t row_buf_idx;
  loop_idx_t    row_buf_row;

  layer_cfg_if cfg_bus ();
  tile_load_if tl_bus ();

  layer_config_reg layer_config_reg_i (
    .clk                          (clk),
    .reset                        (reset),
    .mode_init                    (mode_init),
    .of_init                      (of_init),
    .ox_init                      (ox_init),
    .oy_init                      (oy_init),
    .nif_init                     (nif_init),
    .nif_in_2pow_init             (nif_in_2pow_init),
    .ix_in_2pow_init              (ix_in_2pow_init),
    .input_ddr_layer_base_adr_init(input_ddr_layer_base_adr_init),
    .tilex_first_ix_word_num_init (tilex_first_ix_word_num_init),
    .tilex_mid_ix_word_num_init   (tilex_mid_ix_word_num_init),
    .tilex_last_ix_word_num_init  (tilex_last_ix_word_num_init),
    .tiley_first_iy_row_num_init  (tiley_first_iy_row_num_init),
    .tiley_mid_iy_row_num_init    (tiley_mid_iy_row_num_init),
    .tiley_last_iy_row_num_init   (tiley_last_iy_row_num_init),
    .ix_index_num_init            (ix_index_num_init),
    .iy_index_num_init            (iy_index_num_init),
    .cfg                          (cfg_bus.cfg_src)
  );

  tile_position_sequencer tile_position_sequencer_i (
    .clk                (clk),
    .reset              (reset),
    .conv_load_input    (conv_load_input),
    .cfg                (cfg_bus.cfg_seq),
    .tl                 (tl_bus.seq),
    .conv_load_input_fin(conv_load_input_fin)
  );

  input_word_walker input_word_walker_i (
    .clk          (clk),
    .reset        (reset),
    .ddr_en       (ddr_en),
    .cfg          (cfg_bus.cfg_walk),
    .tl           (tl_bus.walk),
    .rd_en        (input_word_ddr_en_rd),
    .if_start     (if_start),
    .ix_load_index(ix_load_index),
    .iy_load_index(iy_load_index),
    .row_buf_idx  (row_buf_idx),
    .row_buf_row  (row_buf_row)
  );

  ddr_buffer_address_gen ddr_buffer_address_gen_i (
    .cfg          (cfg_bus.cfg_adr),
    .if_start     (if_start),
    .ix_load_index(ix_load_index),
    .iy_load_index(iy_load_index),
    .row_buf_idx  (row_buf_idx),
    .row_buf_row  (row_buf_row),
    .rd_en        (input_word_ddr_en_rd),
    .ddr_adr      (input_word_ddr_adr_rd),
    .fifo_en      (input_word_load_info_fifo_en_wt),
    .fifo_word    (input_word_load_info_fifo_wt)
  );

endmodule

// File: tb/conv_input_load_asserts.sv
module conv_input_load_asserts (
  input logic clk,
  input logic reset,
  input logic conv_load_input,
  input logic ddr_en,
  input logic input_word_ddr_en_rd,
  input logic input_word_load_info_fifo_en_wt,
  input logic conv_load_input_fin
);

  // tile load in flight, from a request without fin up to its fin
  logic load_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      load_busy <= 1'b0;
    end else if (conv_load_input_fin) begin
      load_busy <= 1'b0;
    end else if (conv_load_input) begin
      load_busy <= 1'b1;
    end
  end

  fifo_follows_read: assert property (@(posedge clk) disable iff (reset)
    input_word_load_info_fifo_en_wt == input_word_ddr_en_rd)
    else $error("fifo write strobe differs from ddr read strobe");

  no_read_without_en: assert property (@(posedge clk) disable iff (reset)
    input_word_ddr_en_rd |-> ddr_en)
    else $error("ddr read issued while ddr_en is low");

  // first cycle out of reset is quiet
  quiet_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !input_word_ddr_en_rd && !input_word_load_info_fifo_en_wt
                     && !conv_load_input_fin)
    else $error("strobe or fin high in the first cycle after reset");

  request_when_idle: assert property (@(posedge clk) disable iff (reset)
    conv_load_input |-> !load_busy)
    else $error("request issued while a tile load is still running");

endmodule

bind conv_input_load_top conv_input_load_asserts conv_input_load_asserts_i (
  .clk                            (clk),
  .reset                          (reset),
  .conv_load_input                (conv_load_input),
  .ddr_en                         (ddr_en),
  .input_word_ddr_en_rd           (input_word_ddr_en_rd),
  .input_word_load_info_fifo_en_wt(input_word_load_info_fifo_en_wt),
  .conv_load_input_fin            (conv_load_input_fin)
);

// File: tb/conv_input_load_tb.sv
module conv_input_load_tb;
  import conv_load_pkg::*;

  // one layer of the stimulus table with sizes in words and rows
  typedef struct packed {
    bit mode;
    int of_num;
    int ox;
    int oy;
    int nif;
    int nif_2pow;
    int ix_2pow;
    int ddr_base;
    int tx_first;
    int tx_mid;
    int tx_last;
    int ty_first;
    int ty_mid;
    int ty_last;
    int ix_num;
    int iy_num;
    bit rand_en;
    int n_req;
    int n_reads;
  } layer_row_t;

  localparam int ROWS = 4;

  logic       clk = 1'b0;
  logic       reset;
  logic       conv_load_input;
  logic       ddr_en;
  logic       mode_init;
  loop_idx_t  of_init;
  loop_idx_t  ox_init;
  loop_idx_t  oy_init;
  loop_idx_t  nif_init;
  shift_t     nif_in_2pow_init;
  shift_t     ix_in_2pow_init;
  word_adr_t  input_ddr_layer_base_adr_init;
  size_t      tilex_first_ix_word_num_init;
  size_t      tilex_mid_ix_word_num_init;
  size_t      tilex_last_ix_word_num_init;
  size_t      tiley_first_iy_row_num_init;
  size_t      tiley_mid_iy_row_num_init;
  size_t      tiley_last_iy_row_num_init;
  loop_idx_t  ix_index_num_init;
  loop_idx_t  iy_index_num_init;
  logic       input_word_ddr_en_rd;
  word_adr_t  input_word_ddr_adr_rd;
  logic       input_word_load_info_fifo_en_wt;
  load_info_t input_word_load_info_fifo_wt;
  logic       conv_load_input_fin;

  layer_row_t table_rows [ROWS];
  layer_row_t cur;
  string      test_name;
  int         errors;
  int         checks;
  int         cycles = 0;
  int         cycle_limit = 0;
  bit         en_random;
  bit         fin_now;
  int         reads_now;
  int         row_reads;
  int         row_fins;
  // one based reference read position as in the walker
  int         m_if;
  int         m_ix;
  int         m_iy;
  // reference tile position and f chunk
  int         tile_x;
  int         tile_y;
  int         f_start;
  int         word_shift;
  int         row_shift;
  int         row_mask;

  conv_input_load_top conv_input_load_top_i (.*);

  always #20 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  // first tile, last tile once past the limit, middle otherwise
  function automatic int tile_extent(input int start, input int step, input int limit,
                                     input int first, input int mid, input int last);
    if (start == 1) begin
      return first;
    end else if (start + step > limit) begin
      return last;
    end
    return mid;
  endfunction

  ////////////////////////////////////////
  // reference model of one read
  ////////////////////////////////////////

  task compare_read;
    int col_ofs;
    int if_ofs;
    int ddr_exp;
    int buf_exp;
    col_ofs = (((m_ix - 1) * 32) << word_shift) >> 5;
    if_ofs  = (m_if - 1) / 2;
    ddr_exp = cur.ddr_base + ((m_iy - 1) << row_shift) + col_ofs + if_ofs;
    // buffer row is iy div 3, buffer number iy mod 3 plus 1
    buf_exp = ((((m_iy - 1) / 3) & row_mask) << row_shift) + col_ofs + if_ofs;
    check_value("ddr address", ddr_exp & 'hffff, 32'(input_word_ddr_adr_rd));
    check_value("fifo word", ((((m_iy - 1) % 3) + 1) << 16) | (buf_exp & 'hffff),
                input_word_load_info_fifo_wt);
    // channel pairs step first, then ix and iy across tiles
    m_if = m_if + 2;
    if (m_if > cur.nif) begin
      m_if = 1;
      if (m_ix == cur.ix_num) begin
        m_ix = 1;
        m_iy = (m_iy == cur.iy_num) ? 1 : m_iy + 1;
      end else begin
        m_ix = m_ix + 1;
      end
    end
  endtask

  // sample in the middle of the low phase, then drive at the falling edge
  task next_cycle;
    #10;
    cycles++;
    if (!reset) begin
      if (input_word_ddr_en_rd === 1'b1) begin
        if (ddr_en !== 1'b1) begin
          errors++;
          $display("%s read issued while ddr_en was low", test_name);
        end
        check_value("fifo write strobe", 1, 32'(input_word_load_info_fifo_en_wt));
        compare_read;
        reads_now++;
        row_reads++;
      end
      if (conv_load_input_fin === 1'b1) begin
        fin_now = 1'b1;
        row_fins++;
      end
    end
    @(negedge clk);
    conv_load_input = 1'b0;
    ddr_en = en_random ? ($urandom_range(0, 1) == 1) : 1'b1;
  endtask

  // run limit on the cycle counter
  initial begin
    wait (cycle_limit > 0 && cycles > cycle_limit);
    errors++;
    $display("timeout after %0d cycles, the DUT stopped answering requests", cycles);
    $display("checks %0d, errors %0d", checks, errors);
    $display("RESULT: FAIL");
    $finish;
  end

  task apply_layer(input int r);
    cur       = table_rows[r];
    test_name = $sformatf("layer %0d", r);
    word_shift = cur.nif_2pow - 1;
    row_shift  = word_shift + cur.ix_2pow - 5;
    row_mask   = (1 << (12 - row_shift)) - 1;
    m_if    = 1;
    m_ix    = 1;
    m_iy    = 1;
    tile_x  = 1;
    tile_y  = 1;
    f_start = 1;
    mode_init                     = cur.mode;
    of_init                       = 16'(cur.of_num);
    ox_init                       = 16'(cur.ox);
    oy_init                       = 16'(cur.oy);
    nif_init                      = 16'(cur.nif);
    nif_in_2pow_init              = 4'(cur.nif_2pow);
    ix_in_2pow_init               = 4'(cur.ix_2pow);
    input_ddr_layer_base_adr_init = 16'(cur.ddr_base);
    tilex_first_ix_word_num_init  = 8'(cur.tx_first);
    tilex_mid_ix_word_num_init    = 8'(cur.tx_mid);
    tilex_last_ix_word_num_init   = 8'(cur.tx_last);
    tiley_first_iy_row_num_init   = 8'(cur.ty_first);
    tiley_mid_iy_row_num_init     = 8'(cur.ty_mid);
    tiley_last_iy_row_num_init    = 8'(cur.ty_last);
    ix_index_num_init             = 16'(cur.ix_num);
    iy_index_num_init             = 16'(cur.iy_num);
    en_random = 1'b0;
    reset     = 1'b1;
    repeat (3) next_cycle;
    reset = 1'b0;
  endtask

  task run_request;
    int width;
    int height;
    int exp_reads;
    int row_num;
    bit loaded;
    width     = tile_extent(tile_x, 32, cur.ox, cur.tx_first, cur.tx_mid, cur.tx_last);
    height    = tile_extent(tile_y, 3, cur.oy, cur.ty_first, cur.ty_mid, cur.ty_last);
    row_num   = cur.mode ? 128 : 64;
    // only the first chunk at a position goes to ddr
    loaded    = (f_start != 1);
    exp_reads = loaded ? 0 : width * height * ((cur.nif + 1) / 2);
    reads_now = 0;
    fin_now   = 1'b0;
    conv_load_input = 1'b1;
    next_cycle;
    if (loaded) begin
      check_value("fin with request to a loaded tile", 1, 32'(fin_now));
    end
    while (!fin_now) begin
      next_cycle;
    end
    check_value($sformatf("reads at x %0d y %0d", tile_x, tile_y), exp_reads, reads_now);
    if (f_start + row_num > cur.of_num) begin
      f_start = 1;
      if (tile_x + 32 > cur.ox) begin
        tile_x = 1;
        tile_y = (tile_y + 3 > cur.oy) ? 1 : tile_y + 3;
      end else begin
        tile_x = tile_x + 32;
      end
    end else begin
      f_start = f_start + row_num;
    end
  endtask

  ////////////////////////////////////////
  // stimulus table and main sequence
  ////////////////////////////////////////

  initial begin
    int r;
    int req;
    reset           = 1'b1;
    conv_load_input = 1'b0;
    ddr_en          = 1'b0;
    mode_init       = 1'b0;
    of_init         = '0;
    ox_init         = '0;
    oy_init         = '0;
    nif_init        = '0;
    nif_in_2pow_init = '0;
    ix_in_2pow_init  = '0;
    input_ddr_layer_base_adr_init = '0;
    tilex_first_ix_word_num_init  = '0;
    tilex_mid_ix_word_num_init    = '0;
    tilex_last_ix_word_num_init   = '0;
    tiley_first_iy_row_num_init   = '0;
    tiley_mid_iy_row_num_init     = '0;
    tiley_last_iy_row_num_init    = '0;
    ix_index_num_init = '0;
    iy_index_num_init = '0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    en_random = 1'b0;
    void'($urandom(32'hac96_af6b));
    // mode, of, ox, oy, nif, nif log2, ix log2, base, tilex f/m/l, tiley f/m/l,
    // ix words, iy rows, random ddr_en, requests, reads
    table_rows[0] = '{1'b0, 64, 32, 6, 4, 2, 5, 'h0100, 1, 1, 1, 3, 3, 3, 1, 6,
                      1'b0, 2, 12};
    table_rows[1] = '{1'b0, 64, 32, 6, 4, 2, 5, 'h0200, 1, 1, 1, 3, 3, 3, 1, 6,
                      1'b1, 2, 12};
    table_rows[2] = '{1'b0, 256, 96, 9, 6, 3, 7, 'h1000, 2, 1, 3, 2, 3, 4, 3, 9,
                      1'b1, 36, 162};
    // mode 1 halves the chunk count of layer 2
    table_rows[3] = '{1'b1, 256, 96, 9, 6, 3, 7, 'h2000, 2, 1, 3, 2, 3, 4, 3, 9,
                      1'b0, 18, 162};
    cycle_limit = 200;
    for (r = 0; r < ROWS; r++) begin
      cycle_limit = cycle_limit + 4 * table_rows[r].n_reads + table_rows[r].n_req;
    end
    @(negedge clk);
    for (r = 0; r < ROWS; r++) begin
      apply_layer(r);
      // quiet after reset with ddr_en high
      reads_now = 0;
      row_fins  = 0;
      repeat (10) next_cycle;
      check_value("reads while idle", 0, reads_now);
      check_value("fin while idle", 0, row_fins);
      en_random = cur.rand_en;
      row_reads = 0;
      row_fins  = 0;
      for (req = 0; req < cur.n_req; req++) begin
        run_request;
      end
      // idle tail after the last fin, no fin or read expected here
      repeat (10) next_cycle;
      check_value("fin count", cur.n_req, row_fins);
      check_value("read count", cur.n_reads, row_reads);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+source
source/conv_load_pkg.sv
source/conv_load_ifs.sv
source/layer_config_reg.sv
source/tile_position_sequencer.sv
source/input_word_walker.sv
source/ddr_buffer_address_gen.sv
source/conv_input_load_top.sv
tb/conv_input_load_asserts.sv
tb/conv_input_load_tb.sv

// File: Makefile
TOP := conv_input_load_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
